// ==== hdl/timerPkg.sv ====
package timerPkg;

    // Two packed BCD digits, tens in the upper nibble
    typedef logic [7:0] bcdByte;

    // Display code for the field under the cursor
    typedef logic [7:0] cursorCode;

    // Which direction button fired
    typedef logic [1:0] buttonPulse;

    // Field limits
    localparam bcdByte secondsMax = 8'h59;
    localparam bcdByte minutesMax = 8'h59;
    localparam bcdByte hoursMax   = 8'h23;
    localparam bcdByte bcdZero    = 8'h00;

    // Cursor display codes
    localparam cursorCode cursorSeconds = 8'h41;
    localparam cursorCode cursorMinutes = 8'h42;
    localparam cursorCode cursorHours   = 8'h43;
    localparam cursorCode cursorOff     = 8'h00; // Nothing selected

    // Button pulse codes, listed in priority order
    localparam buttonPulse pulseUp    = 2'd0;
    localparam buttonPulse pulseDown  = 2'd1;
    localparam buttonPulse pulseLeft  = 2'd2;
    localparam buttonPulse pulseRight = 2'd3;

endpackage

// ==== hdl/rtcPkg.sv ====
package rtcPkg;

    // Address or data byte on the RTC side
    typedef logic [7:0] rtcByte;

    // Counter for the delay before the enable write
    typedef logic [11:0] holdCount;

    // Register addresses
    localparam rtcByte rtcControlAddr = 8'h00;
    localparam rtcByte rtcEnableAddr  = 8'h01;

    // Command bytes
    localparam rtcByte rtcStartCmd  = 8'h08; // Timer running
    localparam rtcByte rtcStopCmd   = 8'h00;
    localparam rtcByte rtcEnableCmd = 8'h01;

    // Active cycles before the enable write goes out
    localparam holdCount commandHold = 12'd3380;

endpackage

// ==== hdl/buttonEdges.sv ====
`timescale 1ns/1ps

module buttonEdges (
    input  logic                 clk,
    input  logic                 Reset,
    input  logic                 up,
    input  logic                 down,
    input  logic                 left,
    input  logic                 right,
    output logic                 pulseValid,
    output timerPkg::buttonPulse pulseKind
);
    import timerPkg::*;

    // Bit 0 up, 1 down, 2 left, 3 right
    logic [3:0] stage1;
    logic [3:0] stage2;
    logic [3:0] rising;

    assign rising = stage1 & ~stage2;

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            stage1     <= '0;
            stage2     <= '0;
            pulseValid <= 1'b0;
        end else begin
            stage1     <= {right, left, down, up};
            stage2     <= stage1;
            pulseValid <= |rising;
        end
    end

    // Highest priority wins when several rise together
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) pulseKind <= pulseUp;
        else if (rising[0]) pulseKind <= pulseUp;
        else if (rising[1]) pulseKind <= pulseDown;
        else if (rising[2]) pulseKind <= pulseLeft;
        else if (rising[3]) pulseKind <= pulseRight;
    end

    assert property (@(posedge clk) disable iff (Reset) pulseValid |=> !pulseValid);

endmodule

// ==== hdl/timeSetting.sv ====
`timescale 1ns/1ps

module timeSetting (
    input  logic                 clk,
    input  logic                 Reset,
    input  logic                 programTimer,
    input  logic                 startTimer,
    input  logic                 pulseValid,
    input  timerPkg::buttonPulse pulseKind,
    output timerPkg::cursorCode  cursor,
    output timerPkg::bcdByte     setSeconds,
    output timerPkg::bcdByte     setMinutes,
    output timerPkg::bcdByte     setHours
);
    import timerPkg::*;

    typedef enum logic [1:0] {
        locked,
        editSeconds,
        editMinutes,
        editHours
    } editState;

    editState state;
    logic     stepUp;
    logic     stepDown;
    logic     moveLeft;
    logic     moveRight;
    logic     fieldsValid;

    // One BCD step, saturating at limit going up and at zero going down
    function automatic bcdByte bcdStep(input bcdByte value, input bcdByte limit,
                                       input logic increment);
        bcdByte result;
        result = value;
        if (increment) begin
            if (value < limit) begin
                if (value[3:0] == 4'h9)
                    result = {value[7:4] + 4'h1, 4'h0}; // Carry into tens
                else
                    result = value + 8'h01;
            end
        end else if (value != bcdZero) begin
            if (value[3:0] == 4'h0)
                result = {value[7:4] - 4'h1, 4'h9}; // Borrow from tens
            else
                result = value - 8'h01;
        end
        return result;
    endfunction

    assign stepUp    = pulseValid && (pulseKind == pulseUp);
    assign stepDown  = pulseValid && (pulseKind == pulseDown);
    assign moveLeft  = pulseValid && (pulseKind == pulseLeft);
    assign moveRight = pulseValid && (pulseKind == pulseRight);

    // Cursor FSM
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            state <= locked;
        end else if (!programTimer || startTimer) begin
            state <= locked;
        end else begin
            case (state)
                locked:      state <= editSeconds;
                editSeconds: if (moveLeft) state <= editMinutes;
                editMinutes: begin
                    if (moveLeft)
                        state <= editHours;
                    else if (moveRight)
                        state <= editSeconds;
                end
                editHours:   if (moveRight) state <= editMinutes; // Left stays here
                default:     state <= locked;
            endcase
        end
    end

    // Field registers
    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            setSeconds <= bcdZero;
            setMinutes <= bcdZero;
            setHours   <= bcdZero;
        end else if (stepUp || stepDown) begin
            case (state)
                editSeconds: setSeconds <= bcdStep(setSeconds, secondsMax, stepUp);
                editMinutes: setMinutes <= bcdStep(setMinutes, minutesMax, stepUp);
                editHours:   setHours   <= bcdStep(setHours, hoursMax, stepUp);
                default: ;
            endcase
        end
    end

    always_comb begin
        case (state)
            editSeconds: cursor = cursorSeconds;
            editMinutes: cursor = cursorMinutes;
            editHours:   cursor = cursorHours;
            default:     cursor = cursorOff;
        endcase
    end

    // Digits in range and fields within their limits
    assign fieldsValid = (setSeconds[3:0] <= 4'h9) && (setSeconds <= secondsMax) &&
                         (setMinutes[3:0] <= 4'h9) && (setMinutes <= minutesMax) &&
                         (setHours[3:0] <= 4'h9) && (setHours <= hoursMax);

    assert property (@(posedge clk) disable iff (Reset) fieldsValid);

endmodule

// ==== hdl/runControl.sv ====
`timescale 1ns/1ps

module runControl (
    input  logic             clk,
    input  logic             Reset,
    input  logic             startTimer,
    input  timerPkg::bcdByte setSeconds,
    input  timerPkg::bcdByte setMinutes,
    input  timerPkg::bcdByte setHours,
    input  timerPkg::bcdByte rtcSeconds,
    input  timerPkg::bcdByte rtcMinutes,
    input  timerPkg::bcdByte rtcHours,
    output logic             timerActive,
    output logic             ring
);
    import timerPkg::*;

    typedef enum logic [1:0] {
        idle,
        active,
        done
    } runState;

    runState state;
    logic    timeMatch;
    logic    setNonZero;
    logic    finished;

    assign timeMatch = (rtcSeconds == setSeconds) && (rtcMinutes == setMinutes) &&
                       (rtcHours == setHours);

    // 00:00:00 never counts as an alarm time
    assign setNonZero = (setSeconds != bcdZero) || (setMinutes != bcdZero) ||
                        (setHours != bcdZero);

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            finished <= 1'b0;
        end else begin
            finished <= timeMatch && setNonZero;
        end
    end

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (finished)
                        state <= done;
                    else if (startTimer)
                        state <= active;
                end
                active: begin
                    if (finished)
                        state <= done;
                    else if (!startTimer)
                        state <= idle;
                end
                done: if (!finished && !startTimer) state <= idle; // Wait for release
                default: state <= idle;
            endcase
        end
    end

    assign timerActive = (state == active);
    assign ring        = (state == done);

    assert property (@(posedge clk) disable iff (Reset) !(timerActive && ring));

endmodule

// ==== hdl/rtcCommand.sv ====
`timescale 1ns/1ps

module rtcCommand (
    input  logic           clk,
    input  logic           Reset,
    input  logic           timerActive,
    output rtcPkg::rtcByte rtcAddress,
    output rtcPkg::rtcByte rtcData
);
    import rtcPkg::*;

    holdCount count;
    logic     holdDone;

    // Count parks one past the hold so the enable write fires once
    assign holdDone = (count > commandHold);

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            count <= '0;
        end else if (!timerActive) begin
            count <= '0;
        end else if (!holdDone) begin
            count <= count + 12'd1;
        end
    end

    always_ff @(posedge clk or posedge Reset) begin
        if (Reset) begin
            rtcAddress <= rtcControlAddr;
            rtcData    <= rtcStopCmd;
        end else if (!timerActive) begin
            rtcAddress <= rtcControlAddr; // Stopped
            rtcData    <= rtcStopCmd;
        end else if (count == commandHold) begin
            rtcAddress <= rtcEnableAddr; // Single enable write
            rtcData    <= rtcEnableCmd;
        end else begin
            rtcAddress <= rtcControlAddr;
            rtcData    <= rtcStartCmd;
        end
    end

endmodule

// ==== hdl/countdownTimer.sv ====
`timescale 1ns/1ps

module countdownTimer (
    input  logic                clk,
    input  logic                Reset,
    input  logic                programTimer,
    input  logic                startTimer,
    input  logic                up,
    input  logic                down,
    input  logic                left,
    input  logic                right,
    input  timerPkg::bcdByte    rtcHours,
    input  timerPkg::bcdByte    rtcMinutes,
    input  timerPkg::bcdByte    rtcSeconds,
    output logic                timerActive,
    output logic                ring,
    output timerPkg::cursorCode cursor,
    output rtcPkg::rtcByte      rtcAddress,
    output rtcPkg::rtcByte      rtcData,
    output timerPkg::bcdByte    setHours,
    output timerPkg::bcdByte    setMinutes,
    output timerPkg::bcdByte    setSeconds
);
    import timerPkg::*;

    logic       pulseValid;
    buttonPulse pulseKind;

    buttonEdges buttons (
        .clk        (clk),
        .Reset      (Reset),
        .up         (up),
        .down       (down),
        .left       (left),
        .right      (right),
        .pulseValid (pulseValid),
        .pulseKind  (pulseKind)
    );

    timeSetting setting (
        .clk          (clk),
        .Reset        (Reset),
        .programTimer (programTimer),
        .startTimer   (startTimer),
        .pulseValid   (pulseValid),
        .pulseKind    (pulseKind),
        .cursor       (cursor),
        .setSeconds   (setSeconds),
        .setMinutes   (setMinutes),
        .setHours     (setHours)
    );

    runControl control (
        .clk         (clk),
        .Reset       (Reset),
        .startTimer  (startTimer),
        .setSeconds  (setSeconds),
        .setMinutes  (setMinutes),
        .setHours    (setHours),
        .rtcSeconds  (rtcSeconds),
        .rtcMinutes  (rtcMinutes),
        .rtcHours    (rtcHours),
        .timerActive (timerActive),
        .ring        (ring)
    );

    rtcCommand command (
        .clk         (clk),
        .Reset       (Reset),
        .timerActive (timerActive),
        .rtcAddress  (rtcAddress),
        .rtcData     (rtcData)
    );

endmodule

// ==== bench/countdownTimerTb.sv ====
`timescale 1ns/1ps

module countdownTimerTb;
    import timerPkg::*;
    import rtcPkg::*;

    typedef logic [2:0] buttonSel;
    typedef logic [23:0] clockTime; // hh mm ss as six BCD digits

    localparam buttonSel btnNone  = 3'd0;
    localparam buttonSel btnUp    = 3'd1;
    localparam buttonSel btnDown  = 3'd2;
    localparam buttonSel btnLeft  = 3'd3;
    localparam buttonSel btnRight = 3'd4;

    typedef struct packed {
        buttonSel  button;
        int        presses;
        logic      programLevel;
        logic      startLevel;
        clockTime  rtcTime;
        cursorCode expCursor;
        clockTime  expTime;
        logic      expActive;
        logic      expRing;
    } stimRow;

    logic      clk;
    logic      Reset;
    logic      programTimer;
    logic      startTimer;
    logic      up;
    logic      down;
    logic      left;
    logic      right;
    bcdByte    rtcHours;
    bcdByte    rtcMinutes;
    bcdByte    rtcSeconds;
    logic      timerActive;
    logic      ring;
    cursorCode cursor;
    rtcByte    rtcAddress;
    rtcByte    rtcData;
    bcdByte    setHours;
    bcdByte    setMinutes;
    bcdByte    setSeconds;

    stimRow rows[$];
    int     errors;
    int     testsRun;
    int     testsFailed;
    int     enableWrites;
    logic   testFailed;
    logic   tableBuilt;

    countdownTimer DUT (
        .clk          (clk),
        .Reset        (Reset),
        .programTimer (programTimer),
        .startTimer   (startTimer),
        .up           (up),
        .down         (down),
        .left         (left),
        .right        (right),
        .rtcHours     (rtcHours),
        .rtcMinutes   (rtcMinutes),
        .rtcSeconds   (rtcSeconds),
        .timerActive  (timerActive),
        .ring         (ring),
        .cursor       (cursor),
        .rtcAddress   (rtcAddress),
        .rtcData      (rtcData),
        .setHours     (setHours),
        .setMinutes   (setMinutes),
        .setSeconds   (setSeconds)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Every enable write seen on the RTC bus
    always @(negedge clk) begin
        if (!Reset && rtcAddress == rtcEnableAddr && rtcData == rtcEnableCmd)
            enableWrites = enableWrites + 1;
    end

    task automatic addRow(input buttonSel button, input int presses, input logic programLevel,
                          input logic startLevel, input clockTime rtcTime,
                          input cursorCode expCursor, input clockTime expTime,
                          input logic expActive, input logic expRing);
        stimRow row;
        row.button       = button;
        row.presses      = presses;
        row.programLevel = programLevel;
        row.startLevel   = startLevel;
        row.rtcTime      = rtcTime;
        row.expCursor    = expCursor;
        row.expTime      = expTime;
        row.expActive    = expActive;
        row.expRing      = expRing;
        rows.push_back(row);
    endtask

    task automatic buildTable();
        // Editing, cursor moves and saturation
        addRow(btnNone,  1,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h000000, 1'b0, 1'b0);
        addRow(btnUp,    1,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h000001, 1'b0, 1'b0);
        addRow(btnUp,    8,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h000009, 1'b0, 1'b0);
        addRow(btnUp,    1,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h000010, 1'b0, 1'b0);
        addRow(btnDown,  1,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h000009, 1'b0, 1'b0);
        addRow(btnDown,  9,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h000000, 1'b0, 1'b0);
        addRow(btnDown,  1,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h000000, 1'b0, 1'b0);
        addRow(btnLeft,  1,  1'b1, 1'b0, 24'h123456, cursorMinutes, 24'h000000, 1'b0, 1'b0);
        addRow(btnUp,    1,  1'b1, 1'b0, 24'h123456, cursorMinutes, 24'h000100, 1'b0, 1'b0);
        addRow(btnLeft,  1,  1'b1, 1'b0, 24'h123456, cursorHours,   24'h000100, 1'b0, 1'b0);
        addRow(btnLeft,  1,  1'b1, 1'b0, 24'h123456, cursorHours,   24'h000100, 1'b0, 1'b0);
        addRow(btnUp,    23, 1'b1, 1'b0, 24'h123456, cursorHours,   24'h230100, 1'b0, 1'b0);
        addRow(btnUp,    1,  1'b1, 1'b0, 24'h123456, cursorHours,   24'h230100, 1'b0, 1'b0);
        addRow(btnRight, 1,  1'b1, 1'b0, 24'h123456, cursorMinutes, 24'h230100, 1'b0, 1'b0);
        addRow(btnRight, 1,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h230100, 1'b0, 1'b0);
        addRow(btnRight, 1,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h230100, 1'b0, 1'b0);
        addRow(btnUp,    60, 1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h230159, 1'b0, 1'b0);
        // Run, stop and alarm
        addRow(btnNone,  1,  1'b1, 1'b1, 24'h123456, cursorOff,     24'h230159, 1'b1, 1'b0);
        addRow(btnNone,  1,  1'b0, 1'b0, 24'h123456, cursorOff,     24'h230159, 1'b0, 1'b0);
        addRow(btnNone,  1,  1'b0, 1'b1, 24'h123456, cursorOff,     24'h230159, 1'b1, 1'b0);
        addRow(btnNone,  1,  1'b0, 1'b1, 24'h230159, cursorOff,     24'h230159, 1'b0, 1'b1);
        addRow(btnNone,  1,  1'b0, 1'b1, 24'h123456, cursorOff,     24'h230159, 1'b0, 1'b1);
        addRow(btnNone,  1,  1'b0, 1'b0, 24'h230159, cursorOff,     24'h230159, 1'b0, 1'b1);
        addRow(btnNone,  1,  1'b0, 1'b0, 24'h123456, cursorOff,     24'h230159, 1'b0, 1'b0);
        // Back to 00:00:00, which must never ring
        addRow(btnNone,  1,  1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h230159, 1'b0, 1'b0);
        addRow(btnDown,  59, 1'b1, 1'b0, 24'h123456, cursorSeconds, 24'h230100, 1'b0, 1'b0);
        addRow(btnLeft,  1,  1'b1, 1'b0, 24'h123456, cursorMinutes, 24'h230100, 1'b0, 1'b0);
        addRow(btnDown,  1,  1'b1, 1'b0, 24'h123456, cursorMinutes, 24'h230000, 1'b0, 1'b0);
        addRow(btnLeft,  1,  1'b1, 1'b0, 24'h123456, cursorHours,   24'h230000, 1'b0, 1'b0);
        addRow(btnDown,  23, 1'b1, 1'b0, 24'h123456, cursorHours,   24'h000000, 1'b0, 1'b0);
        addRow(btnNone,  1,  1'b0, 1'b1, 24'h000000, cursorOff,     24'h000000, 1'b1, 1'b0);
        addRow(btnNone,  1,  1'b0, 1'b0, 24'h000000, cursorOff,     24'h000000, 1'b0, 1'b0);
    endtask

    function automatic int totalPresses();
        int sum;
        sum = 0;
        foreach (rows[i])
            sum = sum + rows[i].presses;
        return sum;
    endfunction

    task automatic checkBcd(input string name, input bcdByte actual, input bcdByte expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            errors++;
            testFailed = 1'b1;
        end
    endtask

    task automatic checkCursor(input string name, input cursorCode actual,
                               input cursorCode expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            errors++;
            testFailed = 1'b1;
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            errors++;
            testFailed = 1'b1;
        end
    endtask

    task automatic checkRtc(input string name, input rtcByte actual, input rtcByte expected);
        if (actual !== expected) begin
            $display("FAIL %s: got %h, expected %h", name, actual, expected);
            errors++;
            testFailed = 1'b1;
        end
    endtask

    task automatic driveButton(input buttonSel button, input logic level);
        up    = level && (button == btnUp);
        down  = level && (button == btnDown);
        left  = level && (button == btnLeft);
        right = level && (button == btnRight);
    endtask

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic applyRow(input stimRow row);
        int press;
        programTimer = row.programLevel;
        startTimer   = row.startLevel;
        rtcHours     = row.rtcTime[23:16];
        rtcMinutes   = row.rtcTime[15:8];
        rtcSeconds   = row.rtcTime[7:0];
        for (press = 0; press < row.presses; press++) begin
            driveButton(row.button, 1'b1);
            @(posedge clk);
            #1;
            driveButton(row.button, 1'b0);
            repeat (6) @(posedge clk);
            #1;
        end
    endtask

    task automatic checkRow(input stimRow row);
        checkCursor("cursor", cursor, row.expCursor);
        checkBcd("setHours", setHours, row.expTime[23:16]);
        checkBcd("setMinutes", setMinutes, row.expTime[15:8]);
        checkBcd("setSeconds", setSeconds, row.expTime[7:0]);
        checkBit("timerActive", timerActive, row.expActive);
        checkBit("ring", ring, row.expRing);
        checkRtc("rtcAddress", rtcAddress, rtcControlAddr);
        checkRtc("rtcData", rtcData, row.expActive ? rtcStartCmd : rtcStopCmd);
    endtask

    task automatic finishTest(input string name);
        testsRun++;
        if (testFailed) begin
            testsFailed++;
            $display("%s: failed", name);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    // Long run until the single enable write, then stop
    task automatic runCommandSequence();
        int   waited;
        logic seen;
        testFailed = 1'b0;
        waited     = 0;
        seen       = 1'b0;
        startTimer = 1'b1;
        while (!seen && waited < int'(commandHold) + 3) begin
            @(negedge clk);
            waited++;
            if (rtcAddress == rtcEnableAddr && rtcData == rtcEnableCmd)
                seen = 1'b1;
            else if (waited >= 3) begin // Bus shows start two edges after the level
                checkRtc("rtcAddress", rtcAddress, rtcControlAddr);
                checkRtc("rtcData", rtcData, rtcStartCmd);
            end
        end
        if (!seen) begin
            $display("No enable write appeared within %0d cycles of start", waited);
            errors++;
            testFailed = 1'b1;
        end
        repeat (4) begin
            @(negedge clk);
            checkBit("timerActive", timerActive, 1'b1);
            checkRtc("rtcAddress", rtcAddress, rtcControlAddr);
            checkRtc("rtcData", rtcData, rtcStartCmd);
        end
        @(posedge clk);
        #1 startTimer = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        checkBit("timerActive", timerActive, 1'b0);
        checkRtc("rtcAddress", rtcAddress, rtcControlAddr);
        checkRtc("rtcData", rtcData, rtcStopCmd);
        if (enableWrites != 1) begin
            $display("Expected exactly one enable write cycle but saw %0d", enableWrites);
            errors++;
            testFailed = 1'b1;
        end
        finishTest("enable write");
    endtask

    initial begin
        int limit;
        wait (tableBuilt === 1'b1);
        limit = totalPresses() * 10 + int'(commandHold) + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not complete", limit);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int i;
        errors       = 0;
        testsRun     = 0;
        testsFailed  = 0;
        enableWrites = 0;
        testFailed   = 1'b0;
        tableBuilt   = 1'b0;
        Reset        = 1'b1;
        programTimer = 1'b0;
        startTimer   = 1'b0;
        rtcHours     = 8'h12;
        rtcMinutes   = 8'h34;
        rtcSeconds   = 8'h56;
        driveButton(btnNone, 1'b0);
        buildTable();
        tableBuilt = 1'b1;

        repeat (4) @(posedge clk);
        #1 Reset = 1'b0;
        @(negedge clk);
        checkCursor("cursor", cursor, cursorOff);
        checkBcd("setHours", setHours, 8'h00);
        checkBcd("setMinutes", setMinutes, 8'h00);
        checkBcd("setSeconds", setSeconds, 8'h00);
        checkBit("timerActive", timerActive, 1'b0);
        checkBit("ring", ring, 1'b0);
        checkRtc("rtcAddress", rtcAddress, rtcControlAddr);
        checkRtc("rtcData", rtcData, rtcStopCmd);
        finishTest("reset");

        for (i = 0; i < rows.size(); i++) begin
            testFailed = 1'b0;
            @(posedge clk);
            #1;
            applyRow(rows[i]);
            @(negedge clk);
            checkRow(rows[i]);
            finishTest($sformatf("row %0d", i));
        end

        @(posedge clk);
        #1;
        runCommandSequence();

        $display("Tests: %0d run, %0d failed, %0d check errors", testsRun, testsFailed, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/timerPkg.sv
hdl/rtcPkg.sv
hdl/buttonEdges.sv
hdl/timeSetting.sv
hdl/runControl.sv
hdl/rtcCommand.sv
hdl/countdownTimer.sv
bench/countdownTimerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the countdown timer testbench with Verilator
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module countdownTimerTb -f vlog.f -o countdownTimerSim &&
./obj_dir/countdownTimerSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
